/* rtl/gnn_agg_pkg.sv */
// gnn aggregation package: word widths, destination opcodes and beat formats
package gnn_agg_pkg;

    // ====================
    // widths
    // ====================
    localparam int fv_width   = 16; // one feature word
    localparam int node_width = 8;  // node id

    // ====================
    // destination opcode
    // ====================
    // only looked at on the eos beat of an edge stream
    typedef enum logic [1:0] {
        dest_none   = 2'd0, // keep accumulating
        dest_outbuf = 2'd1, // write partial sum back
        dest_rs     = 2'd2  // final aggregate to reservation station
    } agg_dest_t;

    // ====================
    // beat formats
    // ====================
    typedef struct packed {
        logic [node_width-1:0]        node_id;
        logic [1:0][fv_width-1:0]     fv;      // fv[0] is the even word
        logic                         sos;
        logic                         eos;
        agg_dest_t                    dest;    // valid on eos only
    } edge_beat_t;

    typedef struct packed {
        logic [node_width-1:0]        node_id;
        logic [1:0][fv_width-1:0]     fv;
        logic                         sos;
        logic                         eos;
        agg_dest_t                    dest;    // constant over a packet
    } drain_beat_t;

    typedef struct packed {
        logic [node_width-1:0]        node_id;
        logic [1:0][fv_width-1:0]     fv;
        logic                         sos;
        logic                         eos;
    } out_beat_t;

endpackage

/* rtl/agg_bank.sv */
// aggregation bank: sums edge streams into a local feature buffer and drains it on request
module agg_bank import gnn_agg_pkg::*; #(
    parameter int max_fv = 8 // buffer depth in words, even
) (
    input  logic        clk,
    input  logic        reset,

    // edge stream in
    input  logic        edge_valid,
    input  edge_beat_t  edge_beat,
    output logic        edge_ready,

    // drain out to arbiter
    output logic        drain_valid,
    output drain_beat_t drain_beat,
    input  logic        drain_ready
);

    localparam int n_beats    = max_fv / 2;
    localparam int beat_width = (n_beats > 1) ? $clog2(n_beats) : 1;

    typedef enum logic [1:0] {
        idle,
        stream_in,
        drain
    } state_t;

    // ====================
    // state
    // ====================
    state_t state;

    logic [max_fv-1:0][fv_width-1:0] feat_buf; // two words per beat

    logic [beat_width-1:0] wr_beat;   // word counter, counted in beats
    logic [beat_width-1:0] last_beat; // stream length minus one
    logic [beat_width-1:0] rd_beat;   // drain read index

    logic [node_width-1:0] node_id_q; // from the sos beat
    agg_dest_t             dest_q;    // opcode of the ending stream

    logic [beat_width-1:0] acc_beat;
    logic [beat_width:0]   acc_lo;
    logic [beat_width:0]   acc_hi;
    logic [beat_width:0]   rd_lo;
    logic [beat_width:0]   rd_hi;

    logic edge_fire;
    logic drain_fire;
    logic drain_last;

    // ====================
    // handshakes
    // ====================
    assign edge_ready  = (state != drain);   // blocked while draining
    assign edge_fire   = edge_valid && edge_ready;

    assign drain_valid = (state == drain);
    assign drain_fire  = drain_valid && drain_ready;
    assign drain_last  = (rd_beat == last_beat);

    // a sos beat always lands on word 0
    assign acc_beat = edge_beat.sos ? '0 : wr_beat;

    assign acc_lo = {acc_beat, 1'b0};
    assign acc_hi = {acc_beat, 1'b1};
    assign rd_lo  = {rd_beat, 1'b0};
    assign rd_hi  = {rd_beat, 1'b1};

    // ====================
    // drain beat
    // ====================
    // held stable as long as drain_ready is low, rd_beat only moves on a handshake
    always_comb begin
        drain_beat.node_id = node_id_q;
        drain_beat.fv[0]   = feat_buf[rd_lo];
        drain_beat.fv[1]   = feat_buf[rd_hi];
        drain_beat.sos     = (rd_beat == '0);
        drain_beat.eos     = drain_last;
        drain_beat.dest    = dest_q;
    end

    // ====================
    // fsm and buffer
    // ====================
    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= idle;
            feat_buf  <= '0;
            wr_beat   <= '0;
            last_beat <= '0;
            rd_beat   <= '0;
            dest_q    <= dest_none;
        end else begin
            case (state)
                idle, stream_in: begin
                    if (edge_fire) begin
                        // word-wise add, wraps at fv_width
                        feat_buf[acc_lo] <= feat_buf[acc_lo] + edge_beat.fv[0];
                        feat_buf[acc_hi] <= feat_buf[acc_hi] + edge_beat.fv[1];

                        if (edge_beat.eos) begin
                            wr_beat   <= '0;
                            last_beat <= acc_beat;
                            rd_beat   <= '0;
                            dest_q    <= edge_beat.dest;
                            if (edge_beat.dest == dest_none) begin
                                state <= idle; // partial sum stays in buffer
                            end else begin
                                state <= drain;
                            end
                        end else begin
                            wr_beat <= acc_beat + 1'b1;
                            state   <= stream_in;
                        end
                    end
                end

                drain: begin
                    if (drain_fire) begin
                        if (drain_last) begin
                            feat_buf <= '0;    // next stream sums from zero
                            rd_beat  <= '0;
                            state    <= idle;
                        end else begin
                            rd_beat <= rd_beat + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // node id of the current stream
    always_ff @(posedge clk) begin
        if (edge_fire && edge_beat.sos) begin
            node_id_q <= edge_beat.node_id;
        end
    end

endmodule

/* rtl/drain_arbiter.sv */
// drain arbiter: round-robin packet grant over two banks, routed by destination opcode
module drain_arbiter import gnn_agg_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // bank drains
    input  logic        [1:0] drain_valid,
    input  drain_beat_t [1:0] drain_beat,
    output logic        [1:0] drain_ready,

    // reservation station port
    input  logic              rs_ready,
    output logic              rs_valid,
    output out_beat_t         rs_beat,

    // output buffer port
    input  logic              ob_ready,
    output logic              ob_valid,
    output out_beat_t         ob_beat
);

    // ====================
    // grant state
    // ====================
    logic grant;        // bank holding the packet
    logic last_served;  // bank whose eos went out last
    logic busy;         // packet in progress

    logic        pick;
    logic        cur;
    logic        sel_valid;
    logic        sel_ready;
    logic        sel_fire;
    logic        to_rs;
    logic        to_ob;
    drain_beat_t sel_beat;
    out_beat_t   fwd_beat;

    // choice at a packet boundary
    always_comb begin
        if (drain_valid == 2'b11) begin
            pick = ~last_served; // tie goes to the one not served last
        end else if (drain_valid[1]) begin
            pick = 1'b1;
        end else if (drain_valid[0]) begin
            pick = 1'b0;
        end else begin
            pick = grant;
        end
    end

    assign cur       = busy ? grant : pick;
    assign sel_valid = drain_valid[cur];
    assign sel_beat  = drain_beat[cur];

    // ====================
    // routing
    // ====================
    assign to_rs = (sel_beat.dest == dest_rs);
    assign to_ob = (sel_beat.dest == dest_outbuf);

    assign rs_valid = sel_valid && to_rs;
    assign ob_valid = sel_valid && to_ob;

    always_comb begin
        sel_ready = 1'b0;
        if (to_rs) begin
            sel_ready = rs_ready;
        end else if (to_ob) begin
            sel_ready = ob_ready;
        end
    end

    // ready back to the granted bank only
    always_comb begin
        drain_ready      = 2'b00;
        drain_ready[cur] = sel_ready;
    end

    assign sel_fire = sel_valid && sel_ready;

    always_comb begin
        fwd_beat.node_id = sel_beat.node_id;
        fwd_beat.fv      = sel_beat.fv;
        fwd_beat.sos     = sel_beat.sos;
        fwd_beat.eos     = sel_beat.eos;
    end

    assign rs_beat = fwd_beat; // valid qualifies which one counts
    assign ob_beat = fwd_beat;

    // ====================
    // grant update
    // ====================
    always_ff @(posedge clk) begin
        if (!reset) begin
            grant       <= 1'b0;
            last_served <= 1'b1; // bank 0 first
            busy        <= 1'b0;
        end else begin
            if (!busy && sel_valid) begin
                grant <= pick;   // lock on the presented sos beat
                busy  <= 1'b1;
            end
            if (sel_fire && sel_beat.eos) begin
                busy        <= 1'b0;
                last_served <= cur;
            end
        end
    end

endmodule

/* rtl/agg_subsystem.sv */
// aggregation subsystem: two aggregation banks in parallel feeding one drain arbiter
module agg_subsystem import gnn_agg_pkg::*; #(
    parameter int max_fv = 8 // words per bank buffer
) (
    input  logic             clk,
    input  logic             reset,

    // edge processing element streams
    input  logic       [1:0] edge_valid,
    input  edge_beat_t [1:0] edge_beat,
    output logic       [1:0] edge_ready,

    // reservation station
    input  logic             rs_ready,
    output logic             rs_valid,
    output out_beat_t        rs_beat,

    // output buffer
    input  logic             ob_ready,
    output logic             ob_valid,
    output out_beat_t        ob_beat
);

    // ====================
    // bank to arbiter
    // ====================
    logic        [1:0] drain_valid;
    logic        [1:0] drain_ready;
    drain_beat_t [1:0] drain_beat;

    agg_bank #(
        .max_fv (max_fv)
    ) bank0 (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid[0]),
        .edge_beat   (edge_beat[0]),
        .edge_ready  (edge_ready[0]),
        .drain_valid (drain_valid[0]),
        .drain_beat  (drain_beat[0]),
        .drain_ready (drain_ready[0])
    );

    agg_bank #(
        .max_fv (max_fv)
    ) bank1 (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid[1]),
        .edge_beat   (edge_beat[1]),
        .edge_ready  (edge_ready[1]),
        .drain_valid (drain_valid[1]),
        .drain_beat  (drain_beat[1]),
        .drain_ready (drain_ready[1])
    );

    // one packet at a time to rs or output buffer
    drain_arbiter arb0 (
        .clk         (clk),
        .reset       (reset),
        .drain_valid (drain_valid),
        .drain_beat  (drain_beat),
        .drain_ready (drain_ready),
        .rs_ready    (rs_ready),
        .rs_valid    (rs_valid),
        .rs_beat     (rs_beat),
        .ob_ready    (ob_ready),
        .ob_valid    (ob_valid),
        .ob_beat     (ob_beat)
    );

endmodule

/* tb/tb_clock_gen.sv */
// testbench clock source: free running clock with a fixed period
module tb_clock_gen #(
    parameter int period = 8 // time units per cycle
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk; // half period high, half low
    end

endmodule

/* tb/tb_agg_scoreboard.sv */
// aggregation scoreboard: models both bank buffers and checks every drain beat at the DUT ports
module tb_agg_scoreboard import gnn_agg_pkg::*; #(
    parameter int max_fv = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic       [1:0] edge_valid,
    input  edge_beat_t [1:0] edge_beat,
    input  logic       [1:0] edge_ready,
    input  logic             rs_ready,
    input  logic             rs_valid,
    input  out_beat_t        rs_beat,
    input  logic             ob_ready,
    input  logic             ob_valid,
    input  out_beat_t        ob_beat,
    input  logic             check_alt, // tie rounds, starts must alternate
    output int               pending,
    output int               errors
);

    // ====================
    // model state
    // ====================
    logic [fv_width-1:0]   model_buf [2][max_fv];
    int                    wr_idx [2];
    logic [node_width-1:0] nid [2];
    bit                    draining [2];
    agg_dest_t             exp_dest [2];
    out_beat_t             exp_q0 [$]; // bank 0 expected beats
    out_beat_t             exp_q1 [$];
    bit                    in_pkt [2];  // per port, 0 rs and 1 ob
    int                    cur_bank [2];
    int                    prev_bank;
    bit                    held_v [2];
    out_beat_t             held_beat [2];

    initial begin
        errors  = 0;
        pending = 0;
    end

    task automatic take_edge(input int b);
        int         idx;
        int         k;
        edge_beat_t bt;
        out_beat_t  ex;
        bt  = edge_beat[b];
        idx = bt.sos ? 0 : wr_idx[b];
        model_buf[b][2*idx]   += bt.fv[0]; // wraps at 16 bits
        model_buf[b][2*idx+1] += bt.fv[1];
        if (bt.sos) begin
            nid[b] = bt.node_id;
        end
        wr_idx[b] = idx + 1;
        if (bt.eos) begin
            wr_idx[b] = 0;
            if (bt.dest != dest_none) begin
                for (k = 0; k <= idx; k++) begin
                    ex.node_id = nid[b];
                    ex.fv[0]   = model_buf[b][2*k];
                    ex.fv[1]   = model_buf[b][2*k+1];
                    ex.sos     = (k == 0);
                    ex.eos     = (k == idx);
                    if (b == 0) begin
                        exp_q0.push_back(ex);
                    end else begin
                        exp_q1.push_back(ex);
                    end
                end
                exp_dest[b] = bt.dest;
                draining[b] = 1'b1;
                for (k = 0; k < max_fv; k++) begin
                    model_buf[b][k] = '0; // cleared after the drain
                end
            end
        end
    endtask

    task automatic check_hold(input int port, input logic v, input logic r,
                              input out_beat_t bt, input string name);
        if (held_v[port]) begin
            assert (v) else begin
                $display("%s valid dropped before its handshake", name);
                errors++;
            end
            assert (bt == held_beat[port]) else begin
                $display("ERR %s held exp=%h got=%h", name, held_beat[port], bt);
                errors++;
            end
        end
        held_v[port]    = v && !r;
        held_beat[port] = bt;
    endtask

    task automatic check_out(input int port, input out_beat_t got, input string name);
        int        b;
        bit        ok;
        out_beat_t ex;
        agg_dest_t want;
        b    = got.node_id[node_width-1]; // bank 1 ids from 128 up
        want = (port == 0) ? dest_rs : dest_outbuf;
        ok   = 1'b0;
        ex   = '0;
        if (b == 0 && exp_q0.size() > 0) begin
            ex = exp_q0.pop_front();
            ok = 1'b1;
        end else if (b == 1 && exp_q1.size() > 0) begin
            ex = exp_q1.pop_front();
            ok = 1'b1;
        end
        assert (ok) else begin
            $display("%s carried a beat for bank %0d with nothing pending", name, b);
            errors++;
        end
        if (ok) begin
            assert (exp_dest[b] == want) else begin
                $display("bank %0d packet went out on %s, not on its own port", b, name);
                errors++;
            end
            assert (got == ex) else begin
                $display("ERR %s exp=%h got=%h", name, ex, got);
                errors++;
            end
        end
        assert (!in_pkt[port] || cur_bank[port] == b) else begin
            $display("packets from both banks interleaved on %s", name);
            errors++;
        end
        if (got.sos) begin
            assert (!check_alt || prev_bank != b) else begin
                $display("bank %0d started two packets in a row during tie rounds", b);
                errors++;
            end
            prev_bank = b;
        end
        if (got.eos) begin
            draining[b] = 1'b0;
        end
        in_pkt[port]   = !got.eos;
        cur_bank[port] = b;
    endtask

    // ====================
    // per cycle checks
    // ====================
    always @(posedge clk) begin
        if (!reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int k = 0; k < max_fv; k++) begin
                    model_buf[b][k] = '0;
                end
                wr_idx[b]   = 0;
                draining[b] = 1'b0;
                in_pkt[b]   = 1'b0;
                held_v[b]   = 1'b0;
            end
            exp_q0.delete();
            exp_q1.delete();
            prev_bank = 1; // grant starts at bank 0
            pending   = 0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                assert (edge_ready[b] == !draining[b]) else begin
                    $display("ERR edge_ready[%0d] exp=%h got=%h", b, !draining[b],
                             edge_ready[b]);
                    errors++;
                end
            end
            assert (!(rs_valid && ob_valid)) else begin
                $display("rs_valid and ob_valid were high in the same cycle");
                errors++;
            end
            check_hold(0, rs_valid, rs_ready, rs_beat, "rs_beat");
            check_hold(1, ob_valid, ob_ready, ob_beat, "ob_beat");
            if (rs_valid && rs_ready) begin
                check_out(0, rs_beat, "rs_beat");
            end
            if (ob_valid && ob_ready) begin
                check_out(1, ob_beat, "ob_beat");
            end
            for (int b = 0; b < 2; b++) begin
                if (edge_valid[b] && edge_ready[b]) begin
                    take_edge(b);
                end
            end
            pending = exp_q0.size() + exp_q1.size();
        end
    end

endmodule

/* tb/tb_agg_subsystem.sv */
// aggregation subsystem testbench: drives both edge streams and consumer readies
module tb_agg_subsystem import gnn_agg_pkg::*; ();

    localparam int max_fv  = 8;
    localparam int timeout = 200; // cycles per wait

    logic             clk;
    logic             reset;
    logic       [1:0] edge_valid;
    edge_beat_t [1:0] edge_beat;
    logic       [1:0] edge_ready;
    logic             rs_ready;
    logic             rs_valid;
    out_beat_t        rs_beat;
    logic             ob_ready;
    logic             ob_valid;
    out_beat_t        ob_beat;

    logic        check_alt;
    logic        rand_ready;
    int          pending;
    int          sb_errors;
    int          tb_errors;
    int          tmo_errors;
    logic [31:0] lfsr;

    tb_clock_gen #(.period(8)) clk0 (.clk(clk));

    agg_subsystem #(
        .max_fv (max_fv)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .edge_valid (edge_valid),
        .edge_beat  (edge_beat),
        .edge_ready (edge_ready),
        .rs_ready   (rs_ready),
        .rs_valid   (rs_valid),
        .rs_beat    (rs_beat),
        .ob_ready   (ob_ready),
        .ob_valid   (ob_valid),
        .ob_beat    (ob_beat)
    );

    tb_agg_scoreboard #(.max_fv(max_fv)) sb0 (
        .clk(clk), .reset(reset), .edge_valid(edge_valid), .edge_beat(edge_beat),
        .edge_ready(edge_ready), .rs_ready(rs_ready), .rs_valid(rs_valid),
        .rs_beat(rs_beat), .ob_ready(ob_ready), .ob_valid(ob_valid), .ob_beat(ob_beat),
        .check_alt(check_alt), .pending(pending), .errors(sb_errors)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // consumer readies are random only when enabled
    always @(posedge clk) begin
        #1;
        rs_ready = rand_ready ? rand_bits(1) : 1'b1;
        ob_ready = rand_ready ? rand_bits(1) : 1'b1;
    end

    // ====================
    // stimulus
    // ====================
    task automatic send_stream(input int b, input logic [7:0] node, input int len,
                               input agg_dest_t dest, input bit gaps);
        int         k;
        int         t;
        bit         got;
        edge_beat_t bt;
        for (k = 0; k < len; k++) begin
            if (gaps) begin
                repeat (rand_bits(2)) begin
                    @(posedge clk);
                    #1;
                end
            end
            bt.node_id    = node;
            bt.fv[0]      = rand_bits(16);
            bt.fv[1]      = rand_bits(16);
            bt.sos        = (k == 0);
            bt.eos        = (k == len - 1);
            bt.dest       = bt.eos ? dest : dest_none;
            edge_beat[b]  = bt;
            edge_valid[b] = 1'b1;
            t   = 0;
            got = 1'b0;
            while (!got && t < timeout) begin
                @(posedge clk);
                got = edge_ready[b];
                t++;
            end
            if (!got) begin
                $display("bank %0d never took beat %0d of node %h", b, k, node);
                tmo_errors++;
            end
            #1;
            edge_valid[b] = 1'b0;
        end
    endtask

    task automatic random_traffic(input int b, input int n);
        repeat (n) begin
            send_stream(b, b * 128 + rand_bits(7), rand_bits(2) + 1,
                        agg_dest_t'(rand_bits(2) % 3), 1'b1);
        end
    endtask

    task automatic wait_drained(input string what);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while ((pending != 0 || edge_ready != 2'b11) && t < timeout);
        if (t >= timeout) begin
            $display("%s still had beats pending after %0d cycles", what, timeout);
            tmo_errors++;
        end
    endtask

    initial begin
        lfsr       = 32'hd14d_cb9b;
        reset      = 1'b0;
        edge_valid = 2'b00;
        edge_beat  = '0;
        rs_ready   = 1'b1;
        ob_ready   = 1'b1;
        check_alt  = 1'b0;
        rand_ready = 1'b0;
        tb_errors  = 0;
        tmo_errors = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;

        assert (!rs_valid && !ob_valid && edge_ready == 2'b11) else begin
            $display("outputs not idle after reset");
            tb_errors++;
        end

        send_stream(0, 8'h05, 3, dest_rs, 1'b0); // plain forward
        send_stream(1, 8'h85, 4, dest_rs, 1'b0);
        wait_drained("single rs streams");

        for (int b = 0; b < 2; b++) begin
            send_stream(b, b * 128 + 12, 4, dest_none, 1'b0);
            send_stream(b, b * 128 + 12, 2, dest_none, 1'b0);
            send_stream(b, b * 128 + 12, 3, dest_none, 1'b0);
            send_stream(b, b * 128 + 12, 4, dest_outbuf, 1'b0);
            wait_drained("partial sum write back");
            send_stream(b, b * 128 + 13, 2, dest_outbuf, 1'b0); // from zero
            wait_drained("write back after clear");
        end

        check_alt = 1'b1;
        for (int r = 0; r < 4; r++) begin
            // solo packet first so the tie winner changes every round
            send_stream(r % 2, (r % 2) * 128 + 8'h30 + r, 1, dest_rs, 1'b0);
            wait_drained("solo before tie");
            // both banks end in the same cycle
            fork
                send_stream(0, 8'h20 + r, 3, (r < 2) ? dest_outbuf : dest_rs, 1'b0);
                send_stream(1, 8'ha0 + r, 3, (r < 2) ? dest_outbuf : dest_rs, 1'b0);
            join
            wait_drained("tie round");
        end
        check_alt = 1'b0;

        rand_ready = 1'b1;
        fork
            random_traffic(0, 12);
            random_traffic(1, 12);
        join
        send_stream(0, 8'h7f, 1, dest_rs, 1'b1); // flush what dest_none left
        send_stream(1, 8'hff, 1, dest_outbuf, 1'b1);
        wait_drained("random traffic");
        rand_ready = 1'b0;

        repeat (4) @(posedge clk);
        $display("errors: scoreboard %0d, testbench %0d, timeouts %0d",
                 sb_errors, tb_errors, tmo_errors);
        if (sb_errors == 0 && tb_errors == 0 && tmo_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/gnn_agg_pkg.sv
rtl/agg_bank.sv
rtl/drain_arbiter.sv
rtl/agg_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_agg_scoreboard.sv
tb/tb_agg_subsystem.sv
